// ==== common/rv32i_types.sv ====
package rv32i_types;

    typedef logic [31:0] rv32i_word;

    // any opcode other than these two is not a branch
    typedef enum logic [6:0] {
        op_br  = 7'b1100011,
        op_jal = 7'b1101111
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // two-bit saturating counter whose msb is the taken prediction
    typedef logic [1:0] counter_t;

    localparam counter_t counter_init = 2'b01; // weakly not-taken

    // one instruction word seen either as a B-type or as a J-type layout
    typedef union packed {
        struct packed {
            logic           imm12;
            logic [5:0]     imm10_5;
            logic [4:0]     rs2;
            logic [4:0]     rs1;
            branch_funct3_t funct3;
            logic [3:0]     imm4_1;
            logic           imm11;
            rv32i_opcode    opcode;
        } b_view;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            rv32i_opcode opcode;
        } j_view;
    } instr_u;

endpackage

// ==== predictor/gbht.sv ====
module gbht #(
    parameter s_row_idx   = 5,
    parameter s_pc_offset = 2,
    parameter s_hist      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_id,
    input  logic                  stall_ex,
    input  logic                  update,
    input  logic                  br_en,
    input  rv32i_types::rv32i_word addr,
    output logic                  br_take,
    output logic                  mispred
);

    localparam s_pht  = 2**s_hist;
    localparam s_pipe = s_hist + 3;

    rv32i_types::counter_t pht [s_pht];
    rv32i_types::counter_t ctr_if;
    rv32i_types::counter_t ctr_ex;
    rv32i_types::counter_t ctr_nxt;
    logic [s_hist-1:0]     ghr;
    logic [s_hist-1:0]     ghr_fwd;
    logic [s_row_idx-1:0]  row_if;
    logic [s_hist-1:0]     idx_if;
    logic [s_hist-1:0]     idx_ex;
    logic                  pred_ex;
    logic [s_pipe-1:0]     pipe_if;
    logic [s_pipe-1:0]     pipe_id;
    logic [s_pipe-1:0]     pipe_ex;

    always_comb begin
        if (br_en) begin
            ctr_nxt = (ctr_ex == 2'b11) ? ctr_ex : ctr_ex + 2'b01;
        end else begin
            ctr_nxt = (ctr_ex == 2'b00) ? ctr_ex : ctr_ex - 2'b01;
        end
    end

    // the IF read sees the history and counter as they will be after this update
    assign ghr_fwd = update ? {ghr[s_hist-2:0], br_en} : ghr;
    assign row_if  = addr[s_row_idx+s_pc_offset-1:s_pc_offset];
    assign idx_if  = ghr_fwd ^ row_if[s_hist-1:0];
    assign ctr_if  = (update && idx_if == idx_ex) ? ctr_nxt : pht[idx_if];
    assign br_take = ctr_if[1];

    assign pipe_if = {idx_if, ctr_if, br_take};
    assign {idx_ex, ctr_ex, pred_ex} = pipe_ex;
    assign mispred = pred_ex ^ br_en; // not gated by update here

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
            for (int i = 0; i < s_pht; i++) begin
                pht[i] <= rv32i_types::counter_init;
            end
        end else if (update) begin
            ghr         <= {ghr[s_hist-2:0], br_en};
            pht[idx_ex] <= ctr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_id <= '0;
            pipe_ex <= '0;
        end else begin
            if (!stall_id) pipe_id <= pipe_if;
            if (!stall_ex) pipe_ex <= pipe_id;
        end
    end

endmodule

// ==== predictor/lbht.sv ====
module lbht #(
    parameter s_row_idx   = 5,
    parameter s_pc_offset = 2,
    parameter s_hist      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_id,
    input  logic                  stall_ex,
    input  logic                  update,
    input  logic                  br_en,
    input  rv32i_types::rv32i_word addr,
    output logic                  br_take,
    output logic                  mispred
);

    localparam s_row  = 2**s_row_idx;
    localparam s_pht  = 2**s_hist;
    localparam s_pipe = s_row_idx + s_hist + 3;

    logic [s_hist-1:0]     lht [s_row];
    rv32i_types::counter_t pht [s_pht];
    rv32i_types::counter_t ctr_if;
    rv32i_types::counter_t ctr_ex;
    rv32i_types::counter_t ctr_nxt;
    logic [s_row_idx-1:0]  row_if;
    logic [s_row_idx-1:0]  row_ex;
    logic [s_hist-1:0]     hist_if;
    logic [s_hist-1:0]     hist_ex;
    logic [s_hist-1:0]     hist_nxt;
    logic                  pred_ex;
    logic [s_pipe-1:0]     pipe_if;
    logic [s_pipe-1:0]     pipe_id;
    logic [s_pipe-1:0]     pipe_ex;

    always_comb begin
        if (br_en) begin
            ctr_nxt = (ctr_ex == 2'b11) ? ctr_ex : ctr_ex + 2'b01;
        end else begin
            ctr_nxt = (ctr_ex == 2'b00) ? ctr_ex : ctr_ex - 2'b01;
        end
    end

    assign hist_nxt = {hist_ex[s_hist-2:0], br_en};

    assign row_if  = addr[s_row_idx+s_pc_offset-1:s_pc_offset];
    assign hist_if = (update && row_if == row_ex) ? hist_nxt : lht[row_if];
    assign ctr_if  = (update && hist_if == hist_ex) ? ctr_nxt : pht[hist_if];
    assign br_take = ctr_if[1];

    assign pipe_if = {row_if, hist_if, ctr_if, br_take};
    assign {row_ex, hist_ex, ctr_ex, pred_ex} = pipe_ex;
    assign mispred = pred_ex ^ br_en;

    // the row's local history is the pattern index
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < s_row; i++) begin
                lht[i] <= '0;
            end
            for (int j = 0; j < s_pht; j++) begin
                pht[j] <= rv32i_types::counter_init;
            end
        end else if (update) begin
            lht[row_ex]  <= hist_nxt;
            pht[hist_ex] <= ctr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_id <= '0;
            pipe_ex <= '0;
        end else begin
            if (!stall_id) pipe_id <= pipe_if;
            if (!stall_ex) pipe_ex <= pipe_id;
        end
    end

endmodule

// ==== predictor/tournament_p.sv ====
module tournament_p #(
    parameter s_row_idx   = 5,
    parameter s_pc_offset = 2,
    parameter s_hist      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_id,
    input  logic                  stall_ex,
    input  logic                  update,
    input  logic                  br_en,
    input  logic                  is_jal,
    input  rv32i_types::rv32i_word addr,
    output logic                  br_take,
    output logic                  mispred,
    output logic                  redirect
);

    localparam s_row  = 2**s_row_idx;
    localparam s_pipe = s_row_idx + 3;

    // the msb of a chooser state selects the global table
    localparam logic [1:0] sl = 2'b00;
    localparam logic [1:0] wl = 2'b01;
    localparam logic [1:0] wg = 2'b10;
    localparam logic [1:0] sg = 2'b11;

    logic [1:0]           state_table [s_row];
    logic [s_row_idx-1:0] row_if;
    logic [s_row_idx-1:0] row_ex;
    logic [1:0]           state_if;
    logic [1:0]           state_ex;
    logic [1:0]           state_in;
    logic                 take_ex;
    logic                 g_br_take;
    logic                 l_br_take;
    logic                 g_mispred;
    logic                 l_mispred;
    logic [s_pipe-1:0]    pipe_if;
    logic [s_pipe-1:0]    pipe_id;
    logic [s_pipe-1:0]    pipe_ex;

    gbht #(.s_row_idx(s_row_idx), .s_pc_offset(s_pc_offset), .s_hist(s_hist)) u_gbht (
        .clk, .rst, .stall_id, .stall_ex, .update, .br_en, .addr,
        .br_take (g_br_take),
        .mispred (g_mispred)
    );

    lbht #(.s_row_idx(s_row_idx), .s_pc_offset(s_pc_offset), .s_hist(s_hist)) u_lbht (
        .clk, .rst, .stall_id, .stall_ex, .update, .br_en, .addr,
        .br_take (l_br_take),
        .mispred (l_mispred)
    );

    assign row_if   = addr[s_row_idx+s_pc_offset-1:s_pc_offset];
    assign state_if = (update && row_if == row_ex) ? state_in : state_table[row_if];
    assign br_take  = state_if[1] ? g_br_take : l_br_take;

    assign pipe_if = {row_if, state_if, br_take};
    assign {row_ex, state_ex, take_ex} = pipe_ex;

    assign mispred  = update & (take_ex ^ br_en);
    assign redirect = mispred | is_jal; // jal always refetches from its target

    // train only when exactly one table was wrong
    always_comb begin
        state_in = state_ex;
        if (update && (l_mispred ^ g_mispred)) begin
            case (state_ex)
                sl: state_in = l_mispred ? wl : sl;
                wl: state_in = l_mispred ? wg : sl;
                wg: state_in = g_mispred ? wl : sg;
                sg: state_in = g_mispred ? wg : sg;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < s_row; i++) begin
                state_table[i] <= wl;
            end
        end else if (update) begin
            state_table[row_ex] <= state_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_id <= '0;
            pipe_ex <= '0;
        end else begin
            if (!stall_id) pipe_id <= pipe_if;
            if (!stall_ex) pipe_ex <= pipe_id;
        end
    end

endmodule

// ==== source/branch_decode.sv ====
module branch_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall_ex,
    input  rv32i_types::instr_u         instr_id,
    output logic                       is_branch,
    output logic                       is_jal,
    output rv32i_types::branch_funct3_t funct3,
    output rv32i_types::rv32i_word      imm
);

    logic                   dec_branch;
    logic                   dec_jal;
    rv32i_types::rv32i_word imm_b;
    rv32i_types::rv32i_word imm_j;
    rv32i_types::rv32i_word imm_id;

    // the opcode sits in the same bits in both views
    assign dec_branch = (instr_id.b_view.opcode == rv32i_types::op_br);
    assign dec_jal    = (instr_id.j_view.opcode == rv32i_types::op_jal);

    assign imm_b = {{19{instr_id.b_view.imm12}},
                    instr_id.b_view.imm12,
                    instr_id.b_view.imm11,
                    instr_id.b_view.imm10_5,
                    instr_id.b_view.imm4_1,
                    1'b0};

    assign imm_j = {{11{instr_id.j_view.imm20}},
                    instr_id.j_view.imm20,
                    instr_id.j_view.imm19_12,
                    instr_id.j_view.imm11,
                    instr_id.j_view.imm10_1,
                    1'b0};

    assign imm_id = dec_jal ? imm_j : imm_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            is_branch <= 1'b0;
            is_jal    <= 1'b0;
            funct3    <= rv32i_types::beq;
            imm       <= '0;
        end else if (!stall_ex) begin
            is_branch <= dec_branch;
            is_jal    <= dec_jal;
            funct3    <= instr_id.b_view.funct3; // only meaningful when is_branch
            imm       <= imm_id;
        end
    end

endmodule

// ==== source/branch_resolve.sv ====
module branch_resolve (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall_ex,
    input  rv32i_types::rv32i_word      pc_id,
    input  rv32i_types::rv32i_word      rs1_val,
    input  rv32i_types::rv32i_word      rs2_val,
    input  rv32i_types::rv32i_word      imm,
    input  logic                       is_branch,
    input  logic                       is_jal,
    input  rv32i_types::branch_funct3_t funct3,
    output logic                       br_en,
    output logic                       update,
    output rv32i_types::rv32i_word      target
);

    rv32i_types::rv32i_word pc_ex;
    logic                   eq;
    logic                   lt;
    logic                   ltu;
    logic                   cond;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_ex <= '0;
        end else if (!stall_ex) begin
            pc_ex <= pc_id;
        end
    end

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    always_comb begin
        case (funct3)
            rv32i_types::beq:  cond = eq;
            rv32i_types::bne:  cond = !eq;
            rv32i_types::blt:  cond = lt;
            rv32i_types::bge:  cond = !lt;
            rv32i_types::bltu: cond = ltu;
            rv32i_types::bgeu: cond = !ltu;
            default:           cond = 1'b0; // reserved funct3 never branches
        endcase
    end

    always_comb begin
        if (is_jal) begin
            br_en = 1'b1;
        end else if (is_branch) begin
            br_en = cond;
        end else begin
            br_en = 1'b0;
        end
    end

    // branch and jal targets are both pc relative
    assign target = pc_ex + imm;

    // a held EX stage must not train the tables twice
    assign update = is_branch & ~stall_ex;

endmodule

// ==== source/branch_unit.sv ====
module branch_unit #(
    parameter s_row_idx   = 5,
    parameter s_pc_offset = 2,
    parameter s_hist      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_id,
    input  logic                  stall_ex,
    input  rv32i_types::rv32i_word fetch_addr,
    input  rv32i_types::rv32i_word pc_id,
    input  rv32i_types::instr_u    instr_id,
    input  rv32i_types::rv32i_word rs1_val,
    input  rv32i_types::rv32i_word rs2_val,
    output logic                  br_take,
    output logic                  br_en,
    output logic                  mispred,
    output logic                  redirect,
    output rv32i_types::rv32i_word target
);

    logic                        is_branch;
    logic                        is_jal;
    logic                        update;
    rv32i_types::branch_funct3_t funct3;
    rv32i_types::rv32i_word      imm;

    // decodes in ID and registers the result into EX
    branch_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .stall_ex  (stall_ex),
        .instr_id  (instr_id),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .funct3    (funct3),
        .imm       (imm)
    );

    branch_resolve u_resolve (
        .clk       (clk),
        .rst       (rst),
        .stall_ex  (stall_ex),
        .pc_id     (pc_id),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .imm       (imm),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .funct3    (funct3),
        .br_en     (br_en),
        .update    (update),
        .target    (target)
    );

    // predicts in IF and learns from the EX outcome
    tournament_p #(
        .s_row_idx   (s_row_idx),
        .s_pc_offset (s_pc_offset),
        .s_hist      (s_hist)
    ) u_predictor (
        .clk       (clk),
        .rst       (rst),
        .stall_id  (stall_id),
        .stall_ex  (stall_ex),
        .update    (update),
        .br_en     (br_en),
        .is_jal    (is_jal),
        .addr      (fetch_addr),
        .br_take   (br_take),
        .mispred   (mispred),
        .redirect  (redirect)
    );

endmodule

// ==== sim/tb_branch_unit.sv ====
module tb_branch_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int min_cases    = 43;
    localparam int edge_timeout = 200; // two clock periods in ns

    logic                   clk;
    logic                   rst;
    logic                   stall_id;
    logic                   stall_ex;
    rv32i_types::rv32i_word fetch_addr;
    rv32i_types::rv32i_word pc_id;
    rv32i_types::instr_u    instr_id;
    rv32i_types::rv32i_word rs1_val;
    rv32i_types::rv32i_word rs2_val;
    logic                   br_take;
    logic                   br_en;
    logic                   mispred;
    logic                   redirect;
    rv32i_types::rv32i_word target;

    string                  name_q [$];
    logic [1:0]             stall_q [$]; // {stall_id, stall_ex}
    rv32i_types::rv32i_word fetch_q [$];
    rv32i_types::rv32i_word pc_q [$];
    rv32i_types::rv32i_word instr_q [$];
    rv32i_types::rv32i_word rs1_q [$];
    rv32i_types::rv32i_word rs2_q [$];
    logic [3:0]             flags_q [$]; // {br_take, br_en, mispred, redirect}
    rv32i_types::rv32i_word target_q [$];

    branch_unit u_dut (
        .clk        (clk),
        .rst        (rst),
        .stall_id   (stall_id),
        .stall_ex   (stall_ex),
        .fetch_addr (fetch_addr),
        .pc_id      (pc_id),
        .instr_id   (instr_id),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .br_take    (br_take),
        .br_en      (br_en),
        .mispred    (mispred),
        .redirect   (redirect),
        .target     (target)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string test_name, input string signal,
                             input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s %s: expected %b actual %b",
                                        test_name, signal, expected, actual));
        end
    endtask

    task automatic check_word(input string test_name, input string signal,
                              input rv32i_types::rv32i_word expected,
                              input rv32i_types::rv32i_word actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s %s: expected %h actual %h",
                                        test_name, signal, expected, actual));
        end
    endtask

    // returns shortly after the next rising edge of clk
    task automatic next_rising_edge;
        int waited;
        waited = 0;
        while (clk !== 1'b0) begin
            if (waited >= edge_timeout) stop_with_failure("clock did not fall in time");
            #1;
            waited++;
        end
        while (clk !== 1'b1) begin
            if (waited >= edge_timeout) stop_with_failure("clock did not rise in time");
            #1;
            waited++;
        end
    endtask

    task automatic read_cases;
        int                     fd;
        int                     n;
        string                  line;
        string                  name;
        logic                   sid;
        logic                   sex;
        rv32i_types::rv32i_word f;
        rv32i_types::rv32i_word p;
        rv32i_types::rv32i_word ins;
        rv32i_types::rv32i_word a;
        rv32i_types::rv32i_word b;
        rv32i_types::rv32i_word tgt;
        logic                   t;
        logic                   e;
        logic                   m;
        logic                   r;
        fd = $fopen("sim/branch_cases.txt", "r");
        if (fd == 0) stop_with_failure("cannot open the case file sim/branch_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s %b %b %h %h %h %h %h %b %b %b %b %h",
                        name, sid, sex, f, p, ins, a, b, t, e, m, r, tgt);
            if (n != 13) stop_with_failure({"malformed line in the case file: ", line});
            name_q.push_back(name);
            stall_q.push_back({sid, sex});
            fetch_q.push_back(f);
            pc_q.push_back(p);
            instr_q.push_back(ins);
            rs1_q.push_back(a);
            rs2_q.push_back(b);
            flags_q.push_back({t, e, m, r});
            target_q.push_back(tgt);
        end
        $fclose(fd);
        if (name_q.size() < min_cases) stop_with_failure("the case file is too short");
    endtask

    task automatic drive_case(input int i);
        {stall_id, stall_ex} = stall_q[i];
        fetch_addr = fetch_q[i];
        pc_id      = pc_q[i];
        instr_id   = instr_q[i];
        rs1_val    = rs1_q[i];
        rs2_val    = rs2_q[i];
    endtask

    task automatic check_case(input int i);
        check_bit(name_q[i], "br_take", flags_q[i][3], br_take);
        check_bit(name_q[i], "br_en", flags_q[i][2], br_en);
        check_bit(name_q[i], "mispred", flags_q[i][1], mispred);
        check_bit(name_q[i], "redirect", flags_q[i][0], redirect);
        check_word(name_q[i], "target", target_q[i], target);
    endtask

    initial begin
        int i;
        rst        = 1'b1;
        stall_id   = 1'b0;
        stall_ex   = 1'b0;
        fetch_addr = '0;
        pc_id      = '0;
        instr_id   = 32'h0000_0013; // nop
        rs1_val    = '0;
        rs2_val    = '0;
        read_cases();
        for (i = 0; i < 3; i++) begin
            next_rising_edge();
        end
        #10;
        rst = 1'b0;
        // one case line per clock cycle with the outputs sampled late in the cycle
        for (i = 0; i < name_q.size(); i++) begin
            if (i > 0) begin
                next_rising_edge();
                #10;
            end
            drive_case(i);
            #70;
            check_case(i);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== sim/branch_cases.txt ====
# name stall_id stall_ex fetch_addr pc_id instr_id rs1_val rs2_val
#   then expected br_take br_en mispred redirect target, one line per clock cycle
reset_idle 0 0 00000044 00000000 00000013 00000000 00000000 0 0 0 0 00000000
t1_id      0 0 00000044 00000044 00208463 00000000 00000000 0 0 0 0 00000000
t1_ex      0 0 00000044 00000044 00000013 00000005 00000005 0 1 1 1 0000004c
t2_id      0 0 00000044 00000044 00208463 00000000 00000000 0 0 0 0 00000044
t2_ex      0 0 00000044 00000044 00000013 00000005 00000005 0 1 1 1 0000004c
t3_id      0 0 00000044 00000044 00208463 00000000 00000000 0 0 0 0 00000044
t3_ex      0 0 00000044 00000044 00000013 00000005 00000005 0 1 1 1 0000004c
t4_id      0 0 00000044 00000044 00208463 00000000 00000000 0 0 0 0 00000044
t4_ex      0 0 00000044 00000044 00000013 00000005 00000005 0 1 1 1 0000004c
t5_id      0 0 00000044 00000044 00208463 00000000 00000000 0 0 0 0 00000044
t5_ex      0 0 00000044 00000044 00000013 00000005 00000005 1 1 1 1 0000004c
t6_id      0 0 00000044 00000044 00208463 00000000 00000000 1 0 0 0 00000044
t6_ex      0 0 00000048 00000044 00000013 00000005 00000005 1 1 0 0 0000004c
a1_id      0 0 00000048 00000048 00208463 00000000 00000000 1 0 0 0 00000044
a1_ex      0 0 00000048 00000048 00000013 00000005 00000005 1 1 0 0 00000050
a2_id      0 0 00000048 00000048 00208463 00000000 00000000 1 0 0 0 00000048
a2_ex      0 0 00000048 00000048 00000013 00000003 00000004 0 0 1 1 00000050
a3_id      0 0 00000048 00000048 00208463 00000000 00000000 0 0 0 0 00000048
a3_ex      0 0 00000048 00000048 00000013 00000005 00000005 0 1 1 1 00000050
a4_id      0 0 00000048 00000048 00208463 00000000 00000000 0 0 0 0 00000048
a4_ex      0 0 00000048 00000048 00000013 00000003 00000004 0 0 0 0 00000050
a5_id      0 0 00000048 00000048 00208463 00000000 00000000 0 0 0 0 00000048
a5_ex      0 0 00000048 00000048 00000013 00000005 00000005 0 1 1 1 00000050
a6_id      0 0 00000048 00000048 00208463 00000000 00000000 0 0 0 0 00000048
a6_ex      0 0 00000100 00000048 00000013 00000003 00000004 1 0 0 0 00000050
beq_id     0 0 00000100 00000100 00208463 00000000 00000000 1 0 0 0 00000048
beq_ex     0 0 00000100 00000100 00000013 00000005 00000005 0 1 0 0 00000108
bne_id     0 0 00000100 00000100 00209463 00000000 00000000 0 0 0 0 00000100
bne_ex     0 0 00000100 00000100 00000013 00000005 00000005 1 0 0 0 00000108
blt_id     0 0 00000100 00000100 0020c463 00000000 00000000 1 0 0 0 00000100
blt_ex     0 0 00000100 00000100 00000013 ffffffff 00000001 0 1 0 0 00000108
bge_id     0 0 00000100 00000100 0020d463 00000000 00000000 0 0 0 0 00000100
bge_ex     0 0 00000100 00000100 00000013 ffffffff 00000001 1 0 0 0 00000108
bltu_id    0 0 00000100 00000100 0020e463 00000000 00000000 1 0 0 0 00000100
bltu_ex    0 0 00000100 00000100 00000013 ffffffff 00000001 0 0 1 1 00000108
bgeu_id    0 0 00000100 00000100 fe20fee3 00000000 00000000 0 0 0 0 00000100
bgeu_ex    0 0 00000060 00000100 00000013 ffffffff 00000001 1 1 1 1 000000fc
jal_id     0 0 00000044 00000060 010000ef 00000000 00000000 1 0 0 0 00000100
jal_ex     0 0 00000044 00000044 00208463 00000000 00000000 1 1 0 1 00000070
hold_ex1   1 1 00000044 00000044 00000013 00000003 00000004 1 0 0 0 0000004c
hold_ex2   1 1 00000044 00000044 00000013 00000003 00000004 1 0 0 0 0000004c
release    0 0 00000044 00000044 00000013 00000003 00000004 0 0 1 1 0000004c
after_hold 0 0 00000044 00000044 00000013 00000000 00000000 0 0 0 0 00000044

// ==== verilog.f ====
common/rv32i_types.sv
predictor/gbht.sv
predictor/lbht.sv
predictor/tournament_p.sv
source/branch_decode.sv
source/branch_resolve.sv
source/branch_unit.sv
sim/tb_branch_unit.sv
